/* hdl/knight_cfg.svh */
`ifndef KNIGHT_CFG_SVH
`define KNIGHT_CFG_SVH

//////////////////////////////
// PID coefficients
//////////////////////////////

// Gain on the saturated heading error.
`define KNIGHT_P_COEFF 16

// Gain on the saturated error difference.
`define KNIGHT_D_COEFF 7

// Length of the error history, current sample counted as the first.
`define KNIGHT_D_DEPTH 3

//////////////////////////////
// Motor drive
//////////////////////////////

// PWM counter width; one period is 2**KNIGHT_PWM_BITS cycles.
`define KNIGHT_PWM_BITS 10

//////////////////////////////
// Sample timing
//////////////////////////////

// Fewest cycles allowed between two heading_rdy pulses.
`define KNIGHT_MIN_SPACING 8

`endif

/* hdl/knight_pkg.sv */
package knight_pkg;

  //////////////////////////////
  // Heading path
  //////////////////////////////

  // Heading in 4096ths of a turn, wraps at a full circle.
  typedef logic signed [11:0] heading_t;

  // Heading error, measured minus commanded, shortest way round.
  typedef logic signed [11:0] err_t;

  // Error clamped to +511 / -512.
  typedef logic signed [9:0] err_sat_t;

  //////////////////////////////
  // Speed path
  //////////////////////////////

  // Forward speed, always positive.
  typedef logic [9:0] frwrd_t;

  // Signed wheel speed; sign selects reverse.
  typedef logic signed [10:0] spd_t;

  // Sum of the P, I and D terms.
  typedef logic signed [13:0] pid_term_t;

endpackage

/* hdl/heading_err.sv */
module heading_err (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cmd_vld,          // New commanded heading, one cycle.
  input  knight_pkg::heading_t desired_heading,  // Commanded heading.
  input  logic                 heading_rdy,      // New measured heading, one cycle.
  input  knight_pkg::heading_t heading,          // Measured heading.
  output knight_pkg::err_t     error,            // Held between strobes.
  output logic                 err_vld           // One cycle after heading_rdy.
);

  knight_pkg::heading_t cmd_heading;  // Latched command.
  knight_pkg::err_t     err_wrap;     // Difference folded onto the circle.

  //////////////////////////////
  // Command latch
  //////////////////////////////

  // Holds the last commanded heading until the next cmd_vld.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_heading <= '0;                  // Straight ahead after reset.
    end else if (cmd_vld) begin
      cmd_heading <= desired_heading;
    end
  end

  //////////////////////////////
  // Wrapped error
  //////////////////////////////

  // A 12 bit subtract is modulo 4096 by itself.
  // Read as signed, the result lies in -2048..+2047,
  // so the error always points the shorter way round.
  assign err_wrap = knight_pkg::err_t'(heading - cmd_heading);

  // Register the error on each measurement.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error <= '0;                        // Zero error keeps the PID term at zero.
    end else if (heading_rdy) begin
      error <= err_wrap;                  // Hold value until the next strobe.
    end
  end

  // Strobe goes with the registered error.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_vld <= 1'b0;
    end else begin
      err_vld <= heading_rdy;             // Exactly one cycle per heading_rdy.
    end
  end

endmodule

/* hdl/pid.sv */
`include "knight_cfg.svh"

module pid (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               moving,    // Low clears the speeds and the integrator.
  input  logic               err_vld,   // New error, one cycle.
  input  knight_pkg::err_t   error,     // Heading error from heading_err.
  input  knight_pkg::frwrd_t frwrd,     // Base forward speed.
  output knight_pkg::spd_t   lft_spd,   // Left wheel command.
  output knight_pkg::spd_t   rght_spd   // Right wheel command.
);

  // Valid strobe pipeline.
  logic err_vld_d1, err_vld_d2;         // err_vld_d2 lines up with err_sat.

  // P path.
  knight_pkg::err_sat_t  err_sat0, err_sat;  // Two register saturation stages.
  knight_pkg::pid_term_t p_term;

  // I path.
  logic signed [14:0] err_ext;          // Saturated error widened to 15 bits.
  logic signed [14:0] sum;
  logic signed [14:0] integrator, nxt_integrator;
  logic               ov;               // Same-sign add changed sign.
  logic signed [8:0]  i_term;

  // D path.
  knight_pkg::err_sat_t hist [`KNIGHT_D_DEPTH];  // hist[0] is the newest sample.
  logic signed [10:0]   d_diff;         // One bit wider so the subtract cannot wrap.
  logic signed [7:0]    d_diff_sat;
  logic signed [12:0]   d_term;

  // Sum and outputs.
  knight_pkg::pid_term_t p_half, i_ext, d_ext;
  knight_pkg::pid_term_t pid_term, pid_term_pl;
  knight_pkg::spd_t      pid_top;       // Top 11 bits of the registered sum.
  knight_pkg::spd_t      frwrd_ext;
  knight_pkg::spd_t      raw_lft, raw_rght;

  //////////////////////////////
  // Saturation pipeline
  //////////////////////////////

  // Two stage delay on the strobe to match err_sat0 and err_sat.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_vld_d1 <= 1'b0;
      err_vld_d2 <= 1'b0;
    end else begin
      err_vld_d1 <= err_vld;
      err_vld_d2 <= err_vld_d1;
    end
  end

  // Clamp the 12 bit error to 10 bits, then register once more.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_sat0 <= '0;
      err_sat  <= '0;
    end else begin
      err_sat0 <= (!error[11] && |error[10:9])    ? 10'sh1FF :  // Above +511.
                  (error[11]  && !(&error[10:9])) ? 10'sh200 :  // Below -512.
                  error[9:0];
      err_sat  <= err_sat0;
    end
  end

  // P term follows the second stage.
  assign p_term = knight_pkg::pid_term_t'(err_sat * `KNIGHT_P_COEFF);

  //////////////////////////////
  // Integrator
  //////////////////////////////

  assign err_ext = {{5{err_sat[9]}}, err_sat};
  assign sum     = err_ext + integrator;

  // Overflow only when both operands share a sign the sum lost.
  assign ov = ~(err_ext[14] ^ integrator[14]) & (err_ext[14] ^ sum[14]);

  assign nxt_integrator = !moving                 ? 15'sh0000 :   // Idle, start over.
                          (err_vld_d2 && !ov)     ? sum :
                          integrator;                             // Hold at the limit.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      integrator <= '0;
    end else begin
      integrator <= nxt_integrator;
    end
  end

  assign i_term = integrator[14:6];     // Upper nine bits.

  //////////////////////////////
  // Derivative
  //////////////////////////////

  // Shift register of saturated errors, advanced per valid sample.
  // Kept through moving-low gaps.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `KNIGHT_D_DEPTH; i++) begin
        hist[i] <= '0;
      end
    end else if (err_vld_d2) begin
      hist[0] <= err_sat;
      for (int i = 1; i < `KNIGHT_D_DEPTH; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  // Current error minus the oldest history entry.
  assign d_diff = {err_sat[9], err_sat} - {hist[`KNIGHT_D_DEPTH-1][9], hist[`KNIGHT_D_DEPTH-1]};

  assign d_diff_sat = (!d_diff[10] && |d_diff[9:7])    ? 8'sh7F :  // Above +127.
                      (d_diff[10]  && !(&d_diff[9:7])) ? 8'sh80 :  // Below -128.
                      d_diff[7:0];

  assign d_term = 13'(d_diff_sat * `KNIGHT_D_COEFF);

  //////////////////////////////
  // PID sum
  //////////////////////////////

  assign p_half = p_term >>> 1;                   // P weighted by one half.
  assign i_ext  = {{5{i_term[8]}}, i_term};
  assign d_ext  = {d_term[12], d_term};

  assign pid_term = p_half + i_ext + d_ext;       // Range fits 14 bits.

  // Pipeline register for the sum.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pid_term_pl <= '0;
    end else begin
      pid_term_pl <= pid_term;
    end
  end

  //////////////////////////////
  // Wheel speeds
  //////////////////////////////

  assign pid_top   = pid_term_pl[13:3];
  assign frwrd_ext = {1'b0, frwrd};               // Forward speed is never negative.

  assign raw_lft  = moving ? frwrd_ext + pid_top : 11'sh000;
  assign raw_rght = moving ? frwrd_ext - pid_top : 11'sh000;

  // Positive correction that came out negative wrapped; pin to full forward.
  assign lft_spd  = (!pid_term_pl[13] && raw_lft[10])  ? 11'sh3FF : raw_lft;

  // Same for the right side, where a negative correction adds.
  assign rght_spd = (pid_term_pl[13]  && raw_rght[10]) ? 11'sh3FF : raw_rght;

endmodule

/* hdl/mtr_drv.sv */
`include "knight_cfg.svh"

module mtr_drv (
  input  logic             clk,
  input  logic             rst_n,
  input  knight_pkg::spd_t lft_spd,    // Signed left speed.
  input  knight_pkg::spd_t rght_spd,   // Signed right speed.
  output logic             lft_pwm,    // Left PWM waveform.
  output logic             rght_pwm,   // Right PWM waveform.
  output logic             lft_rev,    // Left wheel runs backward.
  output logic             rght_rev    // Right wheel runs backward.
);

  logic [`KNIGHT_PWM_BITS-1:0] cnt;        // Shared PWM counter.
  logic [`KNIGHT_PWM_BITS-1:0] lft_duty;   // Left high time per period.
  logic [`KNIGHT_PWM_BITS-1:0] rght_duty;  // Right high time per period.

  //////////////////////////////
  // Duty from speed
  //////////////////////////////

  // Magnitude of a signed speed, limited to the counter range.
  // -1024 has magnitude 1024, one step past the top.
  function automatic logic [`KNIGHT_PWM_BITS-1:0] duty_of(input knight_pkg::spd_t spd);
    logic [`KNIGHT_PWM_BITS:0] mag;
    mag = spd[`KNIGHT_PWM_BITS] ? $unsigned(-spd) : $unsigned(spd);
    if (mag[`KNIGHT_PWM_BITS]) begin
      duty_of = {`KNIGHT_PWM_BITS{1'b1}};  // Clamp at 1023.
    end else begin
      duty_of = mag[`KNIGHT_PWM_BITS-1:0];
    end
  endfunction

  assign lft_duty  = duty_of(lft_spd);
  assign rght_duty = duty_of(rght_spd);

  //////////////////////////////
  // PWM counter
  //////////////////////////////

  // Free running; one wrap is one PWM period.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  // High while the counter is below the duty.
  // Over a full period that gives exactly duty high cycles.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lft_pwm  <= 1'b0;
      rght_pwm <= 1'b0;
    end else begin
      lft_pwm  <= (cnt < lft_duty);
      rght_pwm <= (cnt < rght_duty);
    end
  end

  // Direction is the sign bit, registered alongside the PWM.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lft_rev  <= 1'b0;
      rght_rev <= 1'b0;
    end else begin
      lft_rev  <= lft_spd[`KNIGHT_PWM_BITS];   // Sign bit of an 11 bit speed.
      rght_rev <= rght_spd[`KNIGHT_PWM_BITS];
    end
  end

endmodule

/* hdl/heading_ctrl.sv */
module heading_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cmd_vld,          // New command, one cycle.
  input  knight_pkg::heading_t desired_heading,
  input  logic                 heading_rdy,      // New measurement, one cycle.
  input  knight_pkg::heading_t heading,
  input  logic                 moving,           // Level; low stops both wheels.
  input  knight_pkg::frwrd_t   frwrd,            // Base forward speed.
  output knight_pkg::spd_t     lft_spd,          // Telemetry copy of the speeds.
  output knight_pkg::spd_t     rght_spd,
  output logic                 lft_pwm,
  output logic                 rght_pwm,
  output logic                 lft_rev,
  output logic                 rght_rev
);

  knight_pkg::err_t error;    // Wrapped heading error.
  logic             err_vld;  // Error strobe.

  //////////////////////////////
  // Error stage
  //////////////////////////////

  heading_err u_heading_err (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_vld         (cmd_vld),
    .desired_heading (desired_heading),
    .heading_rdy     (heading_rdy),
    .heading         (heading),
    .error           (error),
    .err_vld         (err_vld)
  );

  //////////////////////////////
  // PID stage
  //////////////////////////////

  pid u_pid (
    .clk      (clk),
    .rst_n    (rst_n),
    .moving   (moving),
    .err_vld  (err_vld),
    .error    (error),
    .frwrd    (frwrd),
    .lft_spd  (lft_spd),      // Also drives the motor stage.
    .rght_spd (rght_spd)
  );

  //////////////////////////////
  // Motor stage
  //////////////////////////////

  mtr_drv u_mtr_drv (
    .clk      (clk),
    .rst_n    (rst_n),
    .lft_spd  (lft_spd),
    .rght_spd (rght_spd),
    .lft_pwm  (lft_pwm),
    .rght_pwm (rght_pwm),
    .lft_rev  (lft_rev),
    .rght_rev (rght_rev)
  );

endmodule

/* bench/heading_ctrl_assert.sv */
`include "knight_cfg.svh"

module heading_ctrl_assert (
  input logic             clk,
  input logic             rst_n,
  input logic             err_vld,    // Internal strobe from heading_err.
  input logic             moving,
  input knight_pkg::spd_t lft_spd,
  input knight_pkg::spd_t rght_spd,
  input logic             lft_rev,
  input logic             rght_rev
);

  // Error strobe lasts one cycle.
  a_err_vld_pulse : assert property (@(posedge clk) disable iff (!rst_n)
    err_vld |=> !err_vld)
    else $error("err_vld stayed high for more than one cycle");

  a_idle_speeds : assert property (@(posedge clk) disable iff (!rst_n)
    !moving |-> (lft_spd == '0 && rght_spd == '0))  // Both wheels stop.
    else $error("speed nonzero while moving is low");

  // Direction follows the sign bit one cycle later.
  a_lft_rev : assert property (@(posedge clk) disable iff (!rst_n)
    lft_rev == $past(lft_spd[`KNIGHT_PWM_BITS]))
    else $error("lft_rev does not match the sign of lft_spd");

  a_rght_rev : assert property (@(posedge clk) disable iff (!rst_n)
    rght_rev == $past(rght_spd[`KNIGHT_PWM_BITS]))
    else $error("rght_rev does not match the sign of rght_spd");

endmodule

bind heading_ctrl heading_ctrl_assert u_heading_ctrl_assert (
  .clk      (clk),
  .rst_n    (rst_n),
  .err_vld  (err_vld),
  .moving   (moving),
  .lft_spd  (lft_spd),
  .rght_spd (rght_spd),
  .lft_rev  (lft_rev),
  .rght_rev (rght_rev)
);

/* bench/heading_ctrl_tb.sv */
`include "knight_cfg.svh"

module heading_ctrl_tb;

  //////////////////////////////
  // Run length
  //////////////////////////////

  localparam int CLK_HALF    = 20;              // 40 unit period.
  localparam int DRV_DLY     = 4;               // Input skew after each rising edge.
  localparam int N_WRAP      = 40;              // Strobes per test.
  localparam int N_INTEG     = 40;
  localparam int N_DERIV     = 24;
  localparam int N_IDLE      = 16;
  localparam int N_MOTOR     = 4;
  localparam int GAP_MIN     = `KNIGHT_MIN_SPACING;  // Closest legal strobe spacing.
  localparam int GAP_MAX     = GAP_MIN + 4;
  localparam int MAX_GAP     = GAP_MAX + 2;     // Widest spacing with command and moving steps.
  localparam int PWM_WIN     = 1 << `KNIGHT_PWM_BITS;
  localparam int SPD_MAX     = PWM_WIN - 1;     // 1023.
  localparam int CYCLE_LIMIT = (N_WRAP + N_INTEG + N_DERIV + N_IDLE + N_MOTOR) * MAX_GAP +
                               N_MOTOR * PWM_WIN + 400;

  logic clk, rst_n, cmd_vld, heading_rdy, moving;
  knight_pkg::heading_t desired_heading, heading;
  knight_pkg::frwrd_t   frwrd;
  knight_pkg::spd_t     lft_spd, rght_spd;
  logic lft_pwm, rght_pwm, lft_rev, rght_rev;

  integer seed;
  int cycles = 0;
  int checks, errors, checks_at_start, errors_at_start;

  // Reference state, one update per strobe.
  int ref_cmd;                                  // Latched command heading.
  int ref_integ;                                // 15 bit integrator.
  int ref_hist [`KNIGHT_D_DEPTH];               // Saturated errors, [0] newest.
  int ref_top;                                  // Correction added to frwrd.

  heading_ctrl uut (.*);

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // Run limit.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
      $display("TEST FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // Reference arithmetic
  //////////////////////////////

  function automatic int clamp(input int v, input int lo, input int hi);
    if (v < lo) return lo;
    if (v > hi) return hi;
    return v;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed) & 32'h7fff_ffff;          // Keep it positive.
    return lo + r % (hi - lo + 1);
  endfunction

  // Shortest signed way from command to measurement, 4096 per turn.
  function automatic int wrap_err(input int meas, input int cmd);
    int d;
    d = (meas - cmd) % 4096;
    if (d < 0) d += 4096;
    if (d >= 2048) d -= 4096;
    return d;
  endfunction

  // Wheel speed; a positive overrun pins at full forward.
  function automatic int exp_speed(input int fwd, input int corr, input logic mov);
    if (!mov) return 0;
    return clamp(fwd + corr, -PWM_WIN, SPD_MAX);
  endfunction

  function automatic int pwm_duty(input int spd);
    return clamp((spd < 0) ? -spd : spd, 0, SPD_MAX);
  endfunction

  task automatic ref_sample(input int meas);
    int s, d, pid_sum;
    s = clamp(wrap_err(meas, ref_cmd), -512, 511);
    if (!moving) begin
      ref_integ = 0;                            // Held clear while idle.
    end else if (ref_integ + s >= -16384 && ref_integ + s <= 16383) begin
      ref_integ += s;                           // Out of range means hold.
    end
    for (int i = `KNIGHT_D_DEPTH - 1; i > 0; i--) ref_hist[i] = ref_hist[i-1];
    ref_hist[0] = s;
    d = clamp(s - ref_hist[`KNIGHT_D_DEPTH-1], -128, 127) * `KNIGHT_D_COEFF;
    pid_sum = ((s * `KNIGHT_P_COEFF) >>> 1) + (ref_integ >>> 6) + d;
    ref_top = pid_sum >>> 3;                    // Top 11 of 14 bits.
  endtask

  //////////////////////////////
  // Drive and check
  //////////////////////////////

  task automatic step();
    @(posedge clk);
    #DRV_DLY;
  endtask

  task automatic record_fail(input string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  task automatic check_speeds(input string what);
    int el, er;
    el = exp_speed(frwrd, ref_top, moving);
    er = exp_speed(frwrd, -ref_top, moving);
    checks++;
    assert (int'(lft_spd) == el && int'(rght_spd) == er) else
      record_fail($sformatf("%s speeds %0d/%0d, expected %0d/%0d",
                            what, lft_spd, rght_spd, el, er));
  endtask

  task automatic check_idle(input string what);
    checks++;
    assert (!lft_pwm && !rght_pwm && !lft_rev && !rght_rev && lft_spd == '0 &&
            rght_spd == '0) else
      record_fail($sformatf("%s outputs not idle, pwm %b%b rev %b%b spd %0d/%0d",
                            what, lft_pwm, rght_pwm, lft_rev, rght_rev, lft_spd, rght_spd));
  endtask

  task automatic check_motor(input int el, input int er, input int hl, input int hr);
    checks++;
    assert (hl == pwm_duty(el) && hr == pwm_duty(er)) else
      record_fail($sformatf("PWM highs %0d/%0d for speeds %0d/%0d", hl, hr, el, er));
    checks++;
    assert (lft_rev == (el < 0) && rght_rev == (er < 0)) else
      record_fail($sformatf("rev %b/%b for speeds %0d/%0d", lft_rev, rght_rev, el, er));
  endtask

  task automatic set_cmd(input int cmd);
    cmd_vld         = 1'b1;
    desired_heading = knight_pkg::heading_t'(cmd);
    step();
    cmd_vld = 1'b0;
    ref_cmd = cmd;
  endtask

  task automatic set_moving(input logic mov);
    moving = mov;
    if (!mov) ref_integ = 0;                    // Cleared at the next edge.
    step();
  endtask

  // One heading strobe; speeds checked at k+6, next strobe at k+gap.
  task automatic send_sample(input int meas, input int gap, input string what);
    heading_rdy = 1'b1;
    heading     = knight_pkg::heading_t'(meas);
    step();                                     // Edge k.
    heading_rdy = 1'b0;
    ref_sample(meas);
    repeat (6) step();
    check_speeds(what);
    repeat (gap - 7) step();
  endtask

  task automatic start_test();
    checks_at_start = checks;
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d checks, %0d errors", name, checks - checks_at_start,
             errors - errors_at_start);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin
    int meas, el, er, hl, hr;
    seed            = 32'ha51b;
    rst_n           = 1'b0;
    cmd_vld         = 1'b0;
    desired_heading = '0;
    heading_rdy     = 1'b0;
    heading         = '0;
    moving          = 1'b0;
    frwrd           = '0;
    checks          = 0;
    errors          = 0;
    ref_cmd         = 0;
    ref_integ       = 0;
    ref_top         = 0;
    for (int i = 0; i < `KNIGHT_D_DEPTH; i++) ref_hist[i] = 0;

    start_test();                               // Reset state.
    repeat (4) begin
      step();
      check_idle("in reset");
    end
    rst_n = 1'b1;
    repeat (3) begin
      step();
      check_idle("after reset");
    end
    frwrd  = knight_pkg::frwrd_t'(rand_range(1, SPD_MAX));
    moving = 1'b1;
    repeat (2) step();
    check_speeds("reset, moving");              // PID term still zero.
    checks++;
    assert (!lft_rev && !rght_rev) else
      record_fail($sformatf("rev %b/%b with forward speed %0d", lft_rev, rght_rev, frwrd));
    end_test("reset state");

    start_test();                               // Wrap-around and P path.
    set_cmd(rand_range(0, 4095));
    for (int i = 0; i < N_WRAP; i++) begin
      if (i % 8 == 7) set_cmd(rand_range(0, 4095));
      frwrd = knight_pkg::frwrd_t'(rand_range(0, SPD_MAX));
      meas  = (i % 2) ? rand_range(0, 4095) : ref_cmd + rand_range(-600, 600);
      send_sample(meas, rand_range(GAP_MIN, GAP_MAX), "wrap");
    end
    end_test("wrapped error and P path");

    start_test();                               // Integrator limit.
    set_moving(1'b0);
    set_moving(1'b1);
    for (int i = 0; i < N_INTEG; i++) begin
      frwrd = knight_pkg::frwrd_t'(rand_range(0, SPD_MAX));
      send_sample(ref_cmd + rand_range(600, 1500), rand_range(GAP_MIN, GAP_MAX),
                  "integrator");
    end
    checks++;
    assert (int'(uut.u_pid.integrator) == ref_integ) else
      record_fail($sformatf("integrator %0d, expected %0d",
                            uut.u_pid.integrator, ref_integ));
    end_test("integrator");

    start_test();                               // Derivative with a gap.
    for (int i = 0; i < N_DERIV; i++) begin
      if (i == N_DERIV / 2) begin
        set_moving(1'b0);
        repeat (4) begin
          step();
          check_speeds("D gap");
        end
        set_moving(1'b1);
      end
      frwrd = knight_pkg::frwrd_t'(rand_range(200, 800));
      send_sample(ref_cmd + rand_range(-450, 450), GAP_MIN, "derivative");
    end
    end_test("derivative and history");

    start_test();                               // Idle, then restart.
    set_moving(1'b0);
    for (int i = 0; i < N_IDLE; i++) begin
      if (i == N_IDLE / 2) set_moving(1'b1);
      frwrd = knight_pkg::frwrd_t'(rand_range(0, SPD_MAX));
      send_sample(ref_cmd + rand_range(-1000, 1000), rand_range(GAP_MIN, GAP_MAX),
                  moving ? "after idle" : "idle");
    end
    end_test("moving low");

    start_test();                               // PWM over one full period.
    for (int i = 0; i < N_MOTOR; i++) begin
      frwrd = knight_pkg::frwrd_t'(rand_range(0, 300));
      send_sample(ref_cmd + rand_range(-2048, 2047), GAP_MIN, "motor");
      el = exp_speed(frwrd, ref_top, moving);
      er = exp_speed(frwrd, -ref_top, moving);
      hl = 0;
      hr = 0;
      repeat (PWM_WIN) begin
        step();
        if (lft_pwm) hl++;
        if (rght_pwm) hr++;
      end
      check_motor(el, er, hl, hr);
    end
    end_test("motor drive");

    $display("All tests: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+hdl
hdl/knight_pkg.sv
hdl/heading_err.sv
hdl/pid.sv
hdl/mtr_drv.sv
hdl/heading_ctrl.sv
bench/heading_ctrl_assert.sv
bench/heading_ctrl_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := heading_ctrl_tb
FILELIST   := build.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := TEST FAIL
PASS_MSG   := TEST PASS
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
